// ==== design/cpu_pkg.sv ====
/*
 * shared types for the 16-bit processor
 * word and register index types, opcodes, instruction union, reset word
 */

package cpu_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int DATA_W     = 16;
  localparam int REG_ADDR_W = 4;

  typedef logic signed [DATA_W-1:0] word_t;
  typedef logic [REG_ADDR_W-1:0]    reg_idx_t;

  // top three bits of every instruction
  typedef enum logic [2:0] {
    op_arith    = 3'd0,  // funct 0 add, 1 sub
    op_slt_mult = 3'd1,  // funct 0 slt, 1 mult
    op_load     = 3'd2,
    op_store    = 3'd3,
    op_beq      = 3'd4,
    op_jump     = 3'd5
  } opcode_t;

  // --------------------
  // instruction layout
  // --------------------
  // R and I type share one view; the 5-bit imm sits on top of {rd, funct}
  typedef struct packed {
    opcode_t  opcode;  // 15..13
    reg_idx_t rs;      // 12..9
    reg_idx_t rt;      // 8..5
    reg_idx_t rd;      // 4..1
    logic     funct;   // 0
  } ri_fields_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [12:0] target;  // byte address, bit 0 ignored
  } j_fields_t;

  typedef union packed {
    ri_fields_t ri;
    j_fields_t  j;
  } instr_t;

  // held in the instruction register after reset, never executed
  localparam logic [DATA_W-1:0] NOP_WORD = 16'h4000;

endpackage

// ==== design/pc_counter.sv ====
/*
 * program counter with sequential, branch and jump update
 */
`timescale 1ns/1ps

module pc_counter #(
  parameter int PC_W = 12
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              advance,
  input  logic              branch_taken,
  input  logic              jump_taken,
  input  logic signed [4:0] imm,
  input  logic [12:0]       target,
  output logic [PC_W-1:0]   pc
);

  logic [PC_W-1:0] br_off;

  // (1 + imm) * 2, sign extended to the pc width
  assign br_off = (PC_W'(imm) + PC_W'(1)) <<< 1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (advance) begin
      if (jump_taken)
        pc <= {target[PC_W-1:1], 1'b0};  // halfword aligned
      else if (branch_taken)
        pc <= pc + br_off;
      else
        pc <= pc + PC_W'(2);
    end
  end

endmodule

// ==== design/register_file.sv ====
/*
 * sixteen signed registers
 * two registered read ports, one write port
 */
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rf_read,
  input  reg_idx_t rs_idx,
  input  reg_idx_t rt_idx,
  input  reg_idx_t rd_idx,
  input  logic     rf_write,
  input  word_t    wdata,
  output word_t    rs_val,
  output word_t    rt_val
);

  word_t regs [2**REG_ADDR_W];

  // write port, visible on the following cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++)
        regs[i] <= '0;
    end else if (rf_write) begin
      regs[rd_idx] <= wdata;
    end
  end

  // read ports, held until the next decode
  always_ff @(posedge clk) begin
    if (rf_read) begin
      rs_val <= regs[rs_idx];
      rt_val <= regs[rt_idx];
    end
  end

endmodule

// ==== design/alu.sv ====
/*
 * add, sub, set-less-than, two-stage signed multiply,
 * data address generation and the branch compare
 */
`timescale 1ns/1ps

module alu import cpu_pkg::*; #(
  parameter int                    PC_W       = 12,
  parameter int                    BUS_ADDR_W = 16,
  parameter logic [BUS_ADDR_W-1:0] DATA_BASE  = 16'h1000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  alu_start,
  input  opcode_t               funct_sel,
  input  logic                  funct,
  input  word_t                 rs_val,
  input  word_t                 rt_val,
  input  logic signed [4:0]     imm,
  output word_t                 result,
  output logic                  operands_equal,
  output logic                  mult_done,
  output logic [BUS_ADDR_W-1:0] data_addr
);

  word_t                    mul_a, mul_b, prod_q;
  logic signed [2*DATA_W-1:0] prod_full;
  logic [1:0]               mul_vld;  // stage valid bits
  word_t                    ea;
  logic [DATA_W-1:0]        ea_x2;

  // --------------------
  // multiplier
  // --------------------
  assign prod_full = mul_a * mul_b;

  always_ff @(posedge clk) begin
    if (alu_start) begin
      mul_a <= rs_val;
      mul_b <= rt_val;
    end
    prod_q <= prod_full[DATA_W-1:0];  // low half only
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) mul_vld <= '0;
    else        mul_vld <= {mul_vld[0], alu_start};
  end

  assign mult_done = mul_vld[1];

  // --------------------
  // result mux
  // --------------------
  always_comb begin
    case (funct_sel)
      op_arith:    result = funct ? rs_val - rt_val : rs_val + rt_val;
      op_slt_mult: result = funct ? prod_q : ((rs_val < rt_val) ? word_t'(1) : '0);
      default:     result = rs_val + rt_val;
    endcase
  end

  assign operands_equal = (rs_val == rt_val);

  // (rs + imm) * 2 wraps at the pc width, then the data base is added
  assign ea        = rs_val + word_t'(imm);
  assign ea_x2     = ea <<< 1;
  assign data_addr = DATA_BASE + BUS_ADDR_W'(ea_x2[PC_W-1:0]);

endmodule

// ==== design/mem_handshake.sv ====
/*
 * four-phase req/ack master for the shared memory port
 */
`timescale 1ns/1ps

module mem_handshake import cpu_pkg::*; #(
  parameter int BUS_ADDR_W = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic                  we,
  input  logic [BUS_ADDR_W-1:0] addr,
  input  word_t                 wdata,
  output logic                  done,
  output word_t                 rdata,
  output logic                  mem_req,
  output logic                  mem_we,
  output logic [BUS_ADDR_W-1:0] mem_addr,
  output word_t                 mem_wdata,
  input  logic                  mem_ack,
  input  word_t                 mem_rdata
);

  typedef enum logic [1:0] {HS_IDLE, HS_WAIT_ACK, HS_WAIT_LOW} hs_state_t;

  hs_state_t state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= HS_IDLE;
      mem_req <= 1'b0;
      mem_we  <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        HS_IDLE: if (start) begin
          mem_req <= 1'b1;
          mem_we  <= we;
          state   <= HS_WAIT_ACK;
        end
        HS_WAIT_ACK: if (mem_ack) begin
          mem_req <= 1'b0;  // phase 3
          mem_we  <= 1'b0;
          state   <= HS_WAIT_LOW;
        end
        default: if (!mem_ack) begin
          done  <= 1'b1;  // ack seen low, bus free again
          state <= HS_IDLE;
        end
      endcase
    end
  end

  // address, write data and read data
  always_ff @(posedge clk) begin
    if (state == HS_IDLE && start) begin
      mem_addr  <= addr;
      mem_wdata <= wdata;
    end
    if (state == HS_WAIT_ACK && mem_ack)
      rdata <= mem_rdata;
  end

endmodule

// ==== design/cpu_control_fsm.sv ====
/*
 * instruction sequencer: instruction register, decode and the
 * fetch / decode / execute / memory / retire state machine
 */
`timescale 1ns/1ps

module cpu_control_fsm import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     done,
  input  word_t    rdata,
  input  logic     mult_done,
  input  logic     operands_equal,
  output logic     start,
  output logic     we,
  output logic     addr_sel,       // 1 selects the data address
  output logic     wdata_sel,      // 1 drives rt onto the bus
  output logic     rf_read,
  output logic     rf_write,
  output logic     rf_wsel,        // 1 writes load data
  output reg_idx_t rf_dest,
  output logic     alu_start,
  output logic     advance,
  output logic     branch_taken,
  output logic     jump_taken,
  output instr_t   instr,
  output logic     io_stall
);

  typedef enum logic [2:0] {
    S_FETCH, S_DECODE, S_EXEC, S_MULT, S_MEM, S_RETIRE
  } state_t;

  state_t  state;
  instr_t  instr_q;
  opcode_t op;
  logic    is_alu, is_mult, is_load, is_store, is_beq, is_jump;

  // --------------------
  // decode
  // --------------------
  assign op       = instr_q.ri.opcode;
  assign is_alu   = (op == op_arith) || (op == op_slt_mult && !instr_q.ri.funct);
  assign is_mult  = (op == op_slt_mult) && instr_q.ri.funct;
  assign is_load  = (op == op_load);
  assign is_store = (op == op_store);
  assign is_beq   = (op == op_beq);
  assign is_jump  = (instr_q.j.opcode == op_jump);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= S_FETCH;
      instr_q <= NOP_WORD;
    end else begin
      case (state)
        S_FETCH: if (done) begin
          instr_q <= rdata;  // fetched word
          state   <= S_DECODE;
        end
        S_DECODE: state <= S_EXEC;  // operands being read
        S_EXEC: begin
          if (is_mult)                    state <= S_MULT;
          else if (is_load || is_store)   state <= S_MEM;
          else                            state <= S_RETIRE;
        end
        S_MULT:  state <= S_RETIRE;  // product lands on the retire cycle
        S_MEM:   if (done) state <= S_RETIRE;
        default: state <= S_FETCH;
      endcase
    end
  end

  // --------------------
  // outputs
  // --------------------
  // level request, dropped on done so the idle handshake does not restart
  assign start     = ((state == S_FETCH) || (state == S_MEM)) && !done;
  assign addr_sel  = (state == S_MEM);
  assign we        = (state == S_MEM) && is_store;
  assign wdata_sel = (state == S_MEM) && is_store;

  assign rf_read   = (state == S_DECODE);
  assign rf_wsel   = is_load;
  assign rf_dest   = is_load ? instr_q.ri.rt : instr_q.ri.rd;
  assign rf_write  = (state == S_RETIRE) && (is_alu || is_load || (is_mult && mult_done));

  assign alu_start    = (state == S_EXEC) && is_mult;
  assign advance      = (state == S_RETIRE);
  assign branch_taken = is_beq && operands_equal;
  assign jump_taken   = is_jump;

  assign instr    = instr_q;
  assign io_stall = (state != S_RETIRE);  // low only while retiring

endmodule

// ==== design/cpu_top.sv ====
/*
 * processor top: sequencer, pc, register file, alu and memory port
 */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
  parameter int                    PC_W       = 12,
  parameter int                    BUS_ADDR_W = 16,
  parameter logic [BUS_ADDR_W-1:0] DATA_BASE  = 16'h1000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  output logic                  mem_req,
  output logic                  mem_we,
  output logic [BUS_ADDR_W-1:0] mem_addr,
  output word_t                 mem_wdata,
  input  logic                  mem_ack,
  input  word_t                 mem_rdata,
  output logic                  io_stall
);

  logic                  done, start, we, addr_sel, wdata_sel;
  logic                  rf_read, rf_write, rf_wsel, alu_start, mult_done;
  logic                  advance, branch_taken, jump_taken, operands_equal;
  reg_idx_t              rf_dest;
  instr_t                instr;
  word_t                 hs_rdata, rs_val, rt_val, alu_result;
  logic [PC_W-1:0]       pc;
  logic [BUS_ADDR_W-1:0] data_addr;

  cpu_control_fsm i_ctrl (
    .clk, .rst_n, .done, .rdata(hs_rdata), .mult_done, .operands_equal,
    .start, .we, .addr_sel, .wdata_sel, .rf_read, .rf_write, .rf_wsel,
    .rf_dest, .alu_start, .advance, .branch_taken, .jump_taken, .instr, .io_stall
  );

  pc_counter #(.PC_W(PC_W)) i_pc (
    .clk, .rst_n, .advance, .branch_taken, .jump_taken,
    .imm({instr.ri.rd, instr.ri.funct}), .target(instr.j.target), .pc
  );

  register_file i_rf (
    .clk, .rst_n, .rf_read, .rs_idx(instr.ri.rs), .rt_idx(instr.ri.rt),
    .rd_idx(rf_dest), .rf_write,
    .wdata(rf_wsel ? hs_rdata : alu_result),  // load data or alu result
    .rs_val, .rt_val
  );

  alu #(.PC_W(PC_W), .BUS_ADDR_W(BUS_ADDR_W), .DATA_BASE(DATA_BASE)) i_alu (
    .clk, .rst_n, .alu_start, .funct_sel(instr.ri.opcode), .funct(instr.ri.funct),
    .rs_val, .rt_val, .imm({instr.ri.rd, instr.ri.funct}), .result(alu_result),
    .operands_equal, .mult_done, .data_addr
  );

  // fetch uses the pc, load and store the data address
  mem_handshake #(.BUS_ADDR_W(BUS_ADDR_W)) i_mem (
    .clk, .rst_n, .start, .we,
    .addr(addr_sel ? data_addr : BUS_ADDR_W'(pc)),
    .wdata(wdata_sel ? rt_val : '0),
    .done, .rdata(hs_rdata), .mem_req, .mem_we, .mem_addr, .mem_wdata,
    .mem_ack, .mem_rdata
  );

endmodule

// ==== verification/tb_mem_model.sv ====
/*
 * behavioral memory for the four-phase req/ack port
 * per-request ack delay, store log
 */
`timescale 1ns/1ps

module tb_mem_model import cpu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        mem_req,
  input  logic        mem_we,
  input  logic [15:0] mem_addr,
  input  word_t       mem_wdata,
  input  logic [1:0]  ack_delay,  // extra wait cycles for the next request
  output logic        mem_ack,
  output word_t       mem_rdata
);

  logic [15:0] mem [4096];  // byte addresses 0 to 1fff, loaded by the testbench
  logic [15:0] st_addr [64];
  word_t       st_data [64];
  int          st_count;
  logic [1:0]  wait_cnt;
  logic        busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_ack   <= 1'b0;
      mem_rdata <= '0;
      busy      <= 1'b0;
      wait_cnt  <= '0;
      st_count  <= 0;
    end else if (mem_ack) begin
      if (!mem_req) mem_ack <= 1'b0;  // req gone, finish phase 4
    end else if (mem_req && !busy) begin
      busy     <= 1'b1;
      wait_cnt <= ack_delay;
    end else if (busy && wait_cnt != 0) begin
      wait_cnt <= wait_cnt - 2'd1;
    end else if (busy) begin
      busy      <= 1'b0;
      mem_ack   <= 1'b1;
      mem_rdata <= mem[mem_addr[12:1]];
      if (mem_we) begin
        st_addr[st_count] <= mem_addr;
        st_data[st_count] <= mem_wdata;
        st_count          <= st_count + 1;
      end
    end
  end

endmodule

// ==== verification/cpu_tb.sv ====
/*
 * testbench for the 16-bit processor
 * clock, reset, watchdog, ack delay LFSR, monitor and directed tests
 */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*;;

  localparam int          CLK_PERIOD    = 8;
  localparam logic [15:0] DATA_BASE     = 16'h1000;
  localparam int          TOTAL_RETIRES = 19 + 8 + 19;
  localparam int          WORST_CYCLES  = 30;  // two handshakes at max delay plus exec

  logic        clk, rst_n, rand_ack;
  logic        mem_req, mem_we, mem_ack, io_stall;
  logic [15:0] mem_addr;
  word_t       mem_wdata, mem_rdata;
  logic [1:0]  ack_delay;
  logic [31:0] lfsr;
  int          checks, errors, stall_errors, retire_count, n_fetch;
  logic        req_q, stall_q;
  logic [15:0] fetch_log [64];
  logic [15:0] exp_addr [$];
  word_t       exp_data [$];

  cpu_top #(.DATA_BASE(DATA_BASE)) i_dut (
    .clk, .rst_n, .mem_req, .mem_we, .mem_addr, .mem_wdata,
    .mem_ack, .mem_rdata, .io_stall
  );

  tb_mem_model i_model (
    .clk, .rst_n, .mem_req, .mem_we, .mem_addr, .mem_wdata,
    .ack_delay, .mem_ack, .mem_rdata
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [15:0] r_type(input opcode_t op, input int rs, rt, rd,
                                         input logic f);
    return {op, 4'(rs), 4'(rt), 4'(rd), f};
  endfunction

  function automatic logic [15:0] i_type(input opcode_t op, input int rs, rt, imm);
    return {op, 4'(rs), 4'(rt), 5'(imm)};
  endfunction

  // DATA_BASE + (rs + imm) * 2, offset kept to 12 bits
  function automatic logic [15:0] slot_addr(input int base_val, input int imm);
    return DATA_BASE + 16'(((base_val + imm) * 2) & 32'hfff);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic put_word(input logic [15:0] addr, input logic [15:0] data);
    i_model.mem[addr[12:1]] = data;
  endtask

  task automatic expect_store(input logic [15:0] addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // reset on, memory refilled: code space jumps to itself, data space from address
  task automatic hold_reset();
    logic [15:0] a;
    @(posedge clk);
    #1 rst_n = 1'b0;
    exp_addr.delete();
    exp_data.delete();
    for (int w = 0; w < 4096; w++) begin
      a = 16'(w * 2);
      i_model.mem[w] = (a < 16'h1000) ? {op_jump, a[12:0]} : (a ^ 16'h3c5a);
    end
  endtask

  task automatic run_and_check(input int n_retire);
    @(posedge clk);
    @(negedge clk);
    check_eq("mem_req in reset", mem_req, 0);
    check_eq("io_stall in reset", io_stall, 1);
    @(posedge clk);
    #1 rst_n = 1'b1;
    while (retire_count < n_retire) @(negedge clk);
    check_eq("fetch count", n_fetch, n_retire);  // one pulse per instruction
    check_eq("first fetch address", fetch_log[0], 0);
    check_eq("store count", i_model.st_count, exp_addr.size());
    for (int i = 0; i < exp_addr.size() && i < i_model.st_count; i++) begin
      check_eq("store address", i_model.st_addr[i], exp_addr[i]);
      check_eq("store data", i_model.st_data[i], exp_data[i]);
    end
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic arith_test();
    int    v1, v2, v3, v4, v5;
    word_t res [7];
    v1 = 300;
    v2 = -45;
    v3 = -7;
    v4 = 19;
    v5 = -32767;
    hold_reset();
    put_word(slot_addr(0, 1), 16'(v1));
    put_word(slot_addr(0, 2), 16'(v2));
    put_word(slot_addr(0, 3), 16'(v3));
    put_word(slot_addr(0, 4), 16'(v4));
    put_word(slot_addr(0, 5), 16'(v5));
    for (int k = 0; k < 4; k++) put_word(2 * k, i_type(op_load, 0, k + 1, k + 1));
    put_word(8, i_type(op_load, 0, 11, 5));            // word to be copied
    put_word(10, r_type(op_arith, 1, 2, 5, 1'b0));
    put_word(12, r_type(op_arith, 3, 1, 6, 1'b1));
    put_word(14, r_type(op_slt_mult, 2, 4, 7, 1'b0));  // -45 < 19
    put_word(16, r_type(op_slt_mult, 4, 3, 8, 1'b0));  // 19 < -7 is false
    put_word(18, r_type(op_slt_mult, 1, 3, 9, 1'b1));
    put_word(20, r_type(op_slt_mult, 1, 1, 10, 1'b1)); // product overflows 16 bits
    for (int k = 0; k < 7; k++) put_word(22 + 2 * k, i_type(op_store, 0, 5 + k, 8 + k));
    put_word(36, i_type(op_store, 4, 5, -3));          // negative offset from r4
    res[0] = 16'(v1 + v2);
    res[1] = 16'(v3 - v1);
    res[2] = (v2 < v4) ? 16'd1 : 16'd0;
    res[3] = (v4 < v3) ? 16'd1 : 16'd0;
    res[4] = 16'(v1 * v3);
    res[5] = 16'(v1 * v1);
    res[6] = 16'(v5);
    for (int k = 0; k < 7; k++) expect_store(slot_addr(0, 8 + k), res[k]);
    expect_store(slot_addr(v4, -3), res[0]);
    run_and_check(19);
  endtask

  task automatic branch_test();
    logic [15:0] fetch_exp [8];
    hold_reset();
    put_word(slot_addr(0, 1), 16'd7);
    put_word(slot_addr(0, 2), 16'd7);
    put_word(slot_addr(0, 3), 16'd9);
    for (int k = 0; k < 3; k++) put_word(2 * k, i_type(op_load, 0, k + 1, k + 1));
    put_word(6, i_type(op_beq, 1, 3, 2));      // 7 vs 9, falls through
    put_word(8, i_type(op_beq, 1, 2, 1));      // 8 + (1 + 1) * 2
    put_word(10, i_type(op_store, 0, 1, 10));  // skipped
    put_word(12, i_type(op_store, 0, 3, 4));
    put_word(14, {op_jump, 13'd21});           // odd target, lands on 20
    put_word(16, i_type(op_store, 0, 1, 11));  // skipped
    put_word(18, i_type(op_store, 0, 1, 12));  // skipped
    put_word(20, i_type(op_store, 0, 2, 5));
    expect_store(slot_addr(0, 4), 16'sd9);
    expect_store(slot_addr(0, 5), 16'sd7);
    fetch_exp = '{16'd0, 16'd2, 16'd4, 16'd6, 16'd8, 16'd12, 16'd14, 16'd20};
    run_and_check(8);
    for (int i = 0; i < 8; i++) check_eq("fetch address", fetch_log[i], fetch_exp[i]);
  endtask

  // --------------------
  // stimulus and monitor
  // --------------------
  initial begin
    lfsr      = 32'h56d2d9a4;
    ack_delay = 2'd0;
    forever begin
      @(posedge clk);
      #1;
      if (rand_ack) begin
        ack_delay[0] = lfsr[0];
        lfsr         = lfsr_next(lfsr);
        ack_delay[1] = lfsr[0];
        lfsr         = lfsr_next(lfsr);
      end
    end
  end

  // fetches and retire pulses, sampled away from the active edge
  always @(negedge clk) begin
    if (!rst_n) begin
      retire_count = 0;
      n_fetch      = 0;
      req_q        = 1'b0;
      stall_q      = 1'b1;
    end else begin
      if (mem_req && !req_q && !mem_we && mem_addr < 16'h1000 && n_fetch < 64) begin
        fetch_log[n_fetch] = mem_addr;
        n_fetch++;
      end
      if (!io_stall) begin
        retire_count++;
        if (!stall_q) begin
          stall_errors++;
          $display("io_stall stayed low for more than one cycle at %0t ns", $time);
        end
      end
      req_q   = mem_req;
      stall_q = io_stall;
    end
  end

  initial begin
    #(CLK_PERIOD * (TOTAL_RETIRES * WORST_CYCLES + 12));
    $display("timeout: the DUT did not retire the expected instructions in time");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    rst_n    = 1'b0;
    rand_ack = 1'b0;
    checks   = 0;
    errors   = 0;
    arith_test();
    branch_test();
    rand_ack = 1'b1;  // same program, random ack delays
    arith_test();
    $display("checks: %0d, errors: %0d, io_stall errors: %0d", checks, errors, stall_errors);
    if (errors == 0 && stall_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
design/cpu_pkg.sv
design/pc_counter.sv
design/register_file.sv
design/alu.sv
design/mem_handshake.sv
design/cpu_control_fsm.sv
design/cpu_top.sv
verification/tb_mem_model.sv
verification/cpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing -Wno-fatal
TOP       = cpu_tb
FILELIST  = project.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
